/* lrsc_pkg.sv */
package lrsc_pkg;

    // Default bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int ID_WIDTH   = 2;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int LEN_WIDTH  = 8;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_EXOKAY = 2'b01;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // One response word, read as the raw code or as its two flag bits
    typedef union packed {
        logic [1:0] raw;
        struct packed {
            logic err;
            logic exok;
        } bits;
    } axi_resp_u;

    // True when the address lies inside the closed window
    function automatic logic in_excl_window(
        input logic [63:0] addr,
        input logic [63:0] win_begin,
        input logic [63:0] win_end
    );
        return (addr >= win_begin) && (addr <= win_end);
    endfunction

endpackage

/* lrsc_res_slot.sv */
`timescale 1ns/100ps

module lrsc_res_slot #(
    parameter int ADDR_WIDTH = lrsc_pkg::ADDR_WIDTH,
    parameter int ID_WIDTH   = lrsc_pkg::ID_WIDTH,
    parameter int SLOT_ID    = 0
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  set_i,
    input  logic [ADDR_WIDTH-1:0] set_addr_i,
    input  logic [ID_WIDTH-1:0]   set_id_i,
    input  logic                  clr_i,
    input  logic [ADDR_WIDTH-1:0] clr_addr_i,
    input  logic [ADDR_WIDTH-1:0] chk_addr_i,
    output logic                  hit_o
);

    logic                  valid_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic                  set_own;

    // Only a set carrying this slot's ID loads it
    assign set_own = set_i && (set_id_i == ID_WIDTH'(SLOT_ID));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (set_own) begin
            valid_q <= 1'b1;
        end else if (clr_i && (clr_addr_i == addr_q)) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (set_own) begin
            addr_q <= set_addr_i;
        end
    end

    assign hit_o = valid_q && (addr_q == chk_addr_i);

endmodule

/* lrsc_read_ctrl.sv */
`timescale 1ns/100ps

module lrsc_read_ctrl #(
    parameter logic [63:0] EXCL_BEGIN = 64'h0000_1000,
    parameter logic [63:0] EXCL_END   = 64'h0000_1fff,
    parameter int          ADDR_WIDTH = lrsc_pkg::ADDR_WIDTH,
    parameter int          DATA_WIDTH = lrsc_pkg::DATA_WIDTH,
    parameter int          ID_WIDTH   = lrsc_pkg::ID_WIDTH
) (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic [ADDR_WIDTH-1:0]          slv_ar_addr_i,
    input  logic [ID_WIDTH-1:0]            slv_ar_id_i,
    input  logic [lrsc_pkg::LEN_WIDTH-1:0] slv_ar_len_i,
    input  logic                           slv_ar_lock_i,
    input  logic                           slv_ar_valid_i,
    output logic                           slv_ar_ready_o,
    output logic [ADDR_WIDTH-1:0]          mst_ar_addr_o,
    output logic [ID_WIDTH-1:0]            mst_ar_id_o,
    output logic [lrsc_pkg::LEN_WIDTH-1:0] mst_ar_len_o,
    output logic                           mst_ar_valid_o,
    input  logic                           mst_ar_ready_i,
    input  logic [DATA_WIDTH-1:0]          mst_r_data_i,
    input  logic [1:0]                     mst_r_resp_i,
    input  logic                           mst_r_last_i,
    input  logic [ID_WIDTH-1:0]            mst_r_id_i,
    input  logic                           mst_r_valid_i,
    output logic                           mst_r_ready_o,
    output logic [DATA_WIDTH-1:0]          slv_r_data_o,
    output logic [1:0]                     slv_r_resp_o,
    output logic                           slv_r_last_o,
    output logic [ID_WIDTH-1:0]            slv_r_id_o,
    output logic                           slv_r_valid_o,
    input  logic                           slv_r_ready_i,
    output logic                           res_set_o,
    output logic [ADDR_WIDTH-1:0]          res_addr_o,
    output logic [ID_WIDTH-1:0]            res_id_o
);

    localparam logic [1:0] R_IDLE    = 2'd0;
    localparam logic [1:0] R_WAIT_AR = 2'd1;
    localparam logic [1:0] R_WAIT_R  = 2'd2;

    logic [1:0]          state_d, state_q;
    logic                excl_d, excl_q;
    logic                ar_excl;
    lrsc_pkg::axi_resp_u r_resp;

    // Locked, single beat and inside the window
    assign ar_excl = slv_ar_lock_i && (slv_ar_len_i == '0) &&
                     lrsc_pkg::in_excl_window(64'(slv_ar_addr_i), EXCL_BEGIN, EXCL_END);

    assign mst_ar_addr_o = slv_ar_addr_i;
    assign mst_ar_id_o   = slv_ar_id_i;
    assign mst_ar_len_o  = slv_ar_len_i;
    assign slv_r_data_o  = mst_r_data_i;
    assign slv_r_last_o  = mst_r_last_i;
    assign slv_r_id_o    = mst_r_id_i;
    assign res_addr_o    = slv_ar_addr_i;
    assign res_id_o      = slv_ar_id_i;

    // Errors pass unchanged, other responses report the exclusive outcome
    always_comb begin
        r_resp.raw = mst_r_resp_i;
        if (!r_resp.bits.err) begin
            r_resp.bits.exok = excl_q;
        end
    end
    assign slv_r_resp_o = r_resp.raw;

    always_comb begin
        state_d        = state_q;
        excl_d         = excl_q;
        mst_ar_valid_o = 1'b0;
        slv_ar_ready_o = 1'b0;
        mst_r_ready_o  = 1'b0;
        slv_r_valid_o  = 1'b0;
        res_set_o      = 1'b0;
        case (state_q)
            R_IDLE: begin
                if (slv_ar_valid_i) begin
                    mst_ar_valid_o = 1'b1;
                    slv_ar_ready_o = mst_ar_ready_i;
                    excl_d         = ar_excl;
                    if (mst_ar_ready_i) begin
                        res_set_o = ar_excl;
                        state_d   = R_WAIT_R;
                    end else begin
                        state_d = R_WAIT_AR;
                    end
                end
            end
            R_WAIT_AR: begin
                mst_ar_valid_o = slv_ar_valid_i;
                slv_ar_ready_o = slv_ar_valid_i && mst_ar_ready_i;
                if (slv_ar_valid_i && mst_ar_ready_i) begin
                    res_set_o = excl_q;
                    state_d   = R_WAIT_R;
                end
            end
            R_WAIT_R: begin
                mst_r_ready_o = slv_r_ready_i;
                slv_r_valid_o = mst_r_valid_i;
                if (mst_r_valid_i && slv_r_ready_i && mst_r_last_i) begin
                    excl_d  = 1'b0;
                    state_d = R_IDLE;
                end
            end
            default: begin
                state_d = R_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= R_IDLE;
            excl_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            excl_q  <= excl_d;
        end
    end

endmodule

/* lrsc_write_ctrl.sv */
`timescale 1ns/100ps

module lrsc_write_ctrl #(
    parameter logic [63:0] EXCL_BEGIN = 64'h0000_1000,
    parameter logic [63:0] EXCL_END   = 64'h0000_1fff,
    parameter int          ADDR_WIDTH = lrsc_pkg::ADDR_WIDTH,
    parameter int          DATA_WIDTH = lrsc_pkg::DATA_WIDTH,
    parameter int          ID_WIDTH   = lrsc_pkg::ID_WIDTH,
    localparam int         STRB_WIDTH = DATA_WIDTH / 8
) (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic [ADDR_WIDTH-1:0]          slv_aw_addr_i,
    input  logic [ID_WIDTH-1:0]            slv_aw_id_i,
    input  logic [lrsc_pkg::LEN_WIDTH-1:0] slv_aw_len_i,
    input  logic                           slv_aw_lock_i,
    input  logic                           slv_aw_valid_i,
    output logic                           slv_aw_ready_o,
    output logic [ADDR_WIDTH-1:0]          mst_aw_addr_o,
    output logic [ID_WIDTH-1:0]            mst_aw_id_o,
    output logic [lrsc_pkg::LEN_WIDTH-1:0] mst_aw_len_o,
    output logic                           mst_aw_valid_o,
    input  logic                           mst_aw_ready_i,
    input  logic [DATA_WIDTH-1:0]          slv_w_data_i,
    input  logic [STRB_WIDTH-1:0]          slv_w_strb_i,
    input  logic                           slv_w_last_i,
    input  logic                           slv_w_valid_i,
    output logic                           slv_w_ready_o,
    output logic [DATA_WIDTH-1:0]          mst_w_data_o,
    output logic [STRB_WIDTH-1:0]          mst_w_strb_o,
    output logic                           mst_w_last_o,
    output logic                           mst_w_valid_o,
    input  logic                           mst_w_ready_i,
    input  logic [1:0]                     mst_b_resp_i,
    input  logic [ID_WIDTH-1:0]            mst_b_id_i,
    input  logic                           mst_b_valid_i,
    output logic                           mst_b_ready_o,
    output logic [1:0]                     slv_b_resp_o,
    output logic [ID_WIDTH-1:0]            slv_b_id_o,
    output logic                           slv_b_valid_o,
    input  logic                           slv_b_ready_i,
    input  logic [2**ID_WIDTH-1:0]         hit_i,
    output logic [ADDR_WIDTH-1:0]          chk_addr_o,
    output logic                           clr_o,
    output logic [ADDR_WIDTH-1:0]          clr_addr_o
);

    localparam logic [2:0] W_IDLE    = 3'd0;
    localparam logic [2:0] W_FORWARD = 3'd1;
    localparam logic [2:0] W_BYPASS  = 3'd2;
    localparam logic [2:0] W_DROP    = 3'd3;
    localparam logic [2:0] W_FWD_B   = 3'd4;
    localparam logic [2:0] W_INJ_B   = 3'd5;

    logic [2:0]            state_d, state_q;
    logic                  excl_d, excl_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [ID_WIDTH-1:0]   id_q;
    logic                  aw_in_win;
    logic                  aw_excl;
    logic                  w_last_hs;
    lrsc_pkg::axi_resp_u   b_resp;

    assign aw_in_win = lrsc_pkg::in_excl_window(64'(slv_aw_addr_i), EXCL_BEGIN, EXCL_END);
    assign aw_excl   = slv_aw_lock_i && (slv_aw_len_i == '0);
    assign w_last_hs = slv_w_valid_i && mst_w_ready_i && slv_w_last_i;

    assign mst_aw_addr_o = slv_aw_addr_i;
    assign mst_aw_id_o   = slv_aw_id_i;
    assign mst_aw_len_o  = slv_aw_len_i;
    assign mst_w_data_o  = slv_w_data_i;
    assign mst_w_strb_o  = slv_w_strb_i;
    assign mst_w_last_o  = slv_w_last_i;
    assign chk_addr_o    = slv_aw_addr_i;
    assign clr_addr_o    = addr_q;

    // Keep the error bit, the low bit tells whether the exclusive write succeeded
    always_comb begin
        b_resp.raw = mst_b_resp_i;
        if (!b_resp.bits.err) begin
            b_resp.bits.exok = excl_q;
        end
    end

    always_comb begin
        state_d        = state_q;
        excl_d         = excl_q;
        mst_aw_valid_o = 1'b0;
        slv_aw_ready_o = 1'b0;
        mst_w_valid_o  = 1'b0;
        slv_w_ready_o  = 1'b0;
        mst_b_ready_o  = 1'b0;
        slv_b_valid_o  = 1'b0;
        slv_b_resp_o   = lrsc_pkg::RESP_OKAY;
        slv_b_id_o     = id_q;
        clr_o          = 1'b0;
        case (state_q)
            W_IDLE: begin
                if (slv_aw_valid_i) begin
                    if (aw_in_win && aw_excl && !hit_i[slv_aw_id_i]) begin
                        // No matching reservation, accept and drop the write
                        slv_aw_ready_o = 1'b1;
                        state_d        = W_DROP;
                    end else begin
                        mst_aw_valid_o = 1'b1;
                        slv_aw_ready_o = mst_aw_ready_i;
                        if (mst_aw_ready_i) begin
                            excl_d  = aw_in_win && aw_excl;
                            state_d = aw_in_win ? W_FORWARD : W_BYPASS;
                        end
                    end
                end
            end
            W_FORWARD, W_BYPASS: begin
                mst_w_valid_o = slv_w_valid_i;
                slv_w_ready_o = mst_w_ready_i;
                if (w_last_hs) begin
                    // Window writes kill every reservation on this address
                    clr_o   = (state_q == W_FORWARD);
                    state_d = W_FWD_B;
                end
            end
            W_DROP: begin
                slv_w_ready_o = 1'b1;
                if (slv_w_valid_i && slv_w_last_i) begin
                    state_d = W_INJ_B;
                end
            end
            W_FWD_B: begin
                mst_b_ready_o = slv_b_ready_i;
                slv_b_valid_o = mst_b_valid_i;
                slv_b_resp_o  = b_resp.raw;
                slv_b_id_o    = mst_b_id_i;
                if (mst_b_valid_i && slv_b_ready_i) begin
                    excl_d  = 1'b0;
                    state_d = W_IDLE;
                end
            end
            W_INJ_B: begin
                slv_b_valid_o = 1'b1;
                if (slv_b_ready_i) begin
                    state_d = W_IDLE;
                end
            end
            default: begin
                state_d = W_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= W_IDLE;
            excl_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            excl_q  <= excl_d;
        end
    end

    // AW address and id for the clear and the injected response
    always_ff @(posedge clk_i) begin
        if (slv_aw_valid_i && slv_aw_ready_o) begin
            addr_q <= slv_aw_addr_i;
            id_q   <= slv_aw_id_i;
        end
    end

endmodule

/* lrsc_adapter.sv */
`timescale 1ns/100ps

module lrsc_adapter #(
    parameter logic [63:0] EXCL_BEGIN = 64'h0000_1000,
    parameter logic [63:0] EXCL_END   = 64'h0000_1fff,
    parameter int          ADDR_WIDTH = lrsc_pkg::ADDR_WIDTH,
    parameter int          DATA_WIDTH = lrsc_pkg::DATA_WIDTH,
    parameter int          ID_WIDTH   = lrsc_pkg::ID_WIDTH,
    localparam int         STRB_WIDTH = DATA_WIDTH / 8
) (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    // Upstream side
    input  logic [ADDR_WIDTH-1:0]          slv_ar_addr_i,
    input  logic [ID_WIDTH-1:0]            slv_ar_id_i,
    input  logic [lrsc_pkg::LEN_WIDTH-1:0] slv_ar_len_i,
    input  logic                           slv_ar_lock_i,
    input  logic                           slv_ar_valid_i,
    output logic                           slv_ar_ready_o,
    output logic [DATA_WIDTH-1:0]          slv_r_data_o,
    output logic [1:0]                     slv_r_resp_o,
    output logic                           slv_r_last_o,
    output logic [ID_WIDTH-1:0]            slv_r_id_o,
    output logic                           slv_r_valid_o,
    input  logic                           slv_r_ready_i,
    input  logic [ADDR_WIDTH-1:0]          slv_aw_addr_i,
    input  logic [ID_WIDTH-1:0]            slv_aw_id_i,
    input  logic [lrsc_pkg::LEN_WIDTH-1:0] slv_aw_len_i,
    input  logic                           slv_aw_lock_i,
    input  logic                           slv_aw_valid_i,
    output logic                           slv_aw_ready_o,
    input  logic [DATA_WIDTH-1:0]          slv_w_data_i,
    input  logic [STRB_WIDTH-1:0]          slv_w_strb_i,
    input  logic                           slv_w_last_i,
    input  logic                           slv_w_valid_i,
    output logic                           slv_w_ready_o,
    output logic [1:0]                     slv_b_resp_o,
    output logic [ID_WIDTH-1:0]            slv_b_id_o,
    output logic                           slv_b_valid_o,
    input  logic                           slv_b_ready_i,
    // Downstream side
    output logic [ADDR_WIDTH-1:0]          mst_ar_addr_o,
    output logic [ID_WIDTH-1:0]            mst_ar_id_o,
    output logic [lrsc_pkg::LEN_WIDTH-1:0] mst_ar_len_o,
    output logic                           mst_ar_valid_o,
    input  logic                           mst_ar_ready_i,
    input  logic [DATA_WIDTH-1:0]          mst_r_data_i,
    input  logic [1:0]                     mst_r_resp_i,
    input  logic                           mst_r_last_i,
    input  logic [ID_WIDTH-1:0]            mst_r_id_i,
    input  logic                           mst_r_valid_i,
    output logic                           mst_r_ready_o,
    output logic [ADDR_WIDTH-1:0]          mst_aw_addr_o,
    output logic [ID_WIDTH-1:0]            mst_aw_id_o,
    output logic [lrsc_pkg::LEN_WIDTH-1:0] mst_aw_len_o,
    output logic                           mst_aw_valid_o,
    input  logic                           mst_aw_ready_i,
    output logic [DATA_WIDTH-1:0]          mst_w_data_o,
    output logic [STRB_WIDTH-1:0]          mst_w_strb_o,
    output logic                           mst_w_last_o,
    output logic                           mst_w_valid_o,
    input  logic                           mst_w_ready_i,
    input  logic [1:0]                     mst_b_resp_i,
    input  logic [ID_WIDTH-1:0]            mst_b_id_i,
    input  logic                           mst_b_valid_i,
    output logic                           mst_b_ready_o
);

    localparam int N_SLOTS = 2 ** ID_WIDTH;

    logic                  res_set;
    logic [ADDR_WIDTH-1:0] res_addr;
    logic [ID_WIDTH-1:0]   res_id;
    logic                  clr;
    logic [ADDR_WIDTH-1:0] clr_addr;
    logic [ADDR_WIDTH-1:0] chk_addr;
    logic [N_SLOTS-1:0]    hit;

    // Channel ports share their names with the top level
    lrsc_read_ctrl #(
        .EXCL_BEGIN (EXCL_BEGIN),
        .EXCL_END   (EXCL_END),
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) u_read_ctrl (
        .*,
        .res_set_o  (res_set),
        .res_addr_o (res_addr),
        .res_id_o   (res_id)
    );

    lrsc_write_ctrl #(
        .EXCL_BEGIN (EXCL_BEGIN),
        .EXCL_END   (EXCL_END),
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) u_write_ctrl (
        .*,
        .hit_i      (hit),
        .chk_addr_o (chk_addr),
        .clr_o      (clr),
        .clr_addr_o (clr_addr)
    );

    // One reservation slot per transaction ID
    for (genvar i = 0; i < N_SLOTS; i++) begin : g_slot
        lrsc_res_slot #(
            .ADDR_WIDTH (ADDR_WIDTH),
            .ID_WIDTH   (ID_WIDTH),
            .SLOT_ID    (i)
        ) u_slot (
            .clk_i      (clk_i),
            .rst_ni     (rst_ni),
            .set_i      (res_set),
            .set_addr_i (res_addr),
            .set_id_i   (res_id),
            .clr_i      (clr),
            .clr_addr_i (clr_addr),
            .chk_addr_i (chk_addr),
            .hit_o      (hit[i])
        );
    end

endmodule

/* tb_lrsc.sv */
`timescale 1ns/100ps

module tb_lrsc;

    localparam logic [63:0] WIN_BEGIN = 64'h0000_1000;
    localparam logic [63:0] WIN_END   = 64'h0000_1fff;
    localparam int          AW        = lrsc_pkg::ADDR_WIDTH;
    localparam int          DW        = lrsc_pkg::DATA_WIDTH;
    localparam int          IW        = lrsc_pkg::ID_WIDTH;
    localparam int          LW        = lrsc_pkg::LEN_WIDTH;
    localparam int          TIMEOUT   = 100;

    logic            clk_i = 1'b0;
    logic            rst_ni;
    logic [AW-1:0]   slv_ar_addr_i, slv_aw_addr_i, mst_ar_addr_o, mst_aw_addr_o;
    logic [IW-1:0]   slv_ar_id_i, slv_aw_id_i, slv_r_id_o, slv_b_id_o;
    logic [IW-1:0]   mst_ar_id_o, mst_aw_id_o, mst_r_id_i, mst_b_id_i;
    logic [LW-1:0]   slv_ar_len_i, slv_aw_len_i, mst_ar_len_o, mst_aw_len_o;
    logic [DW-1:0]   slv_r_data_o, mst_r_data_i, slv_w_data_i, mst_w_data_o;
    logic [DW/8-1:0] slv_w_strb_i, mst_w_strb_o;
    logic [1:0]      slv_r_resp_o, mst_r_resp_i, slv_b_resp_o, mst_b_resp_i;
    logic            slv_ar_lock_i, slv_ar_valid_i, slv_ar_ready_o;
    logic            slv_aw_lock_i, slv_aw_valid_i, slv_aw_ready_o;
    logic            slv_r_last_o, slv_r_valid_o, slv_r_ready_i;
    logic            slv_w_last_i, slv_w_valid_i, slv_w_ready_o;
    logic            slv_b_valid_o, slv_b_ready_i;
    logic            mst_ar_valid_o, mst_ar_ready_i, mst_aw_valid_o, mst_aw_ready_i;
    logic            mst_r_last_i, mst_r_valid_i, mst_r_ready_o;
    logic            mst_w_last_o, mst_w_valid_o, mst_w_ready_i;
    logic            mst_b_valid_i, mst_b_ready_o;

    logic [DW-1:0]   mem [logic [AW-1:0]];
    logic            slave_err;
    int              aw_count;
    int              test_errs;
    bit              aborted;

    lrsc_adapter #(
        .EXCL_BEGIN (WIN_BEGIN),
        .EXCL_END   (WIN_END),
        .ADDR_WIDTH (AW),
        .DATA_WIDTH (DW),
        .ID_WIDTH   (IW)
    ) dut (.*);

    always #4 clk_i = ~clk_i;

    // Unwritten words read back as the inverted address
    function automatic logic [DW-1:0] mem_read(input logic [AW-1:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return DW'(~addr);
    endfunction

    // Downstream memory, ready held high, each answer one cycle after its handshake
    initial begin : slave_model
        logic            ar_hs, r_hs, w_hs, b_hs;
        logic [AW-1:0]   ar_addr, aw_addr;
        logic [IW-1:0]   ar_id, aw_id;
        logic [LW-1:0]   ar_len, aw_len;
        logic [DW-1:0]   w_data;
        logic [DW/8-1:0] w_strb;
        logic [DW-1:0]   w_word;
        aw_count = 0;
        {mst_ar_ready_i, mst_aw_ready_i, mst_w_ready_i} = '1;
        {mst_r_data_i, mst_r_resp_i, mst_r_last_i, mst_r_id_i, mst_r_valid_i} = '0;
        {mst_b_resp_i, mst_b_id_i, mst_b_valid_i} = '0;
        forever begin
            // Falling edge sees the values that the next rising edge will take
            @(negedge clk_i);
            ar_hs   = mst_ar_valid_o && mst_ar_ready_i;
            r_hs    = mst_r_valid_i && mst_r_ready_o;
            w_hs    = mst_w_valid_o && mst_w_ready_i && mst_w_last_o;
            b_hs    = mst_b_valid_i && mst_b_ready_o;
            ar_addr = mst_ar_addr_o;
            ar_id   = mst_ar_id_o;
            ar_len  = mst_ar_len_o;
            w_data  = mst_w_data_o;
            w_strb  = mst_w_strb_o;
            if (mst_aw_valid_o === 1'b1) begin
                aw_count++;
                aw_addr = mst_aw_addr_o;
                aw_id   = mst_aw_id_o;
                aw_len  = mst_aw_len_o;
            end
            @(posedge clk_i);
            #1;
            if (r_hs) mst_r_valid_i = 1'b0;
            if (b_hs) mst_b_valid_i = 1'b0;
            // Single-beat memory, bursts answer SLVERR
            if (ar_hs) begin
                mst_r_valid_i = 1'b1;
                mst_r_data_i  = mem_read(ar_addr);
                mst_r_resp_i  = (slave_err || ar_len != '0) ? lrsc_pkg::RESP_SLVERR
                                                            : lrsc_pkg::RESP_OKAY;
                mst_r_id_i    = ar_id;
                mst_r_last_i  = 1'b1;
            end
            if (w_hs) begin
                // An erroring slave leaves the word untouched
                if (!slave_err && aw_len == '0) begin
                    w_word = mem_read(aw_addr);
                    for (int b = 0; b < DW / 8; b++) begin
                        if (w_strb[b]) w_word[8*b +: 8] = w_data[8*b +: 8];
                    end
                    mem[aw_addr] = w_word;
                end
                mst_b_valid_i = 1'b1;
                mst_b_resp_i  = (slave_err || aw_len != '0) ? lrsc_pkg::RESP_SLVERR
                                                            : lrsc_pkg::RESP_OKAY;
                mst_b_id_i    = aw_id;
            end
        end
    end

    function automatic logic probe(input int which);
        case (which)
            0: return slv_ar_ready_o;
            1: return slv_r_valid_o;
            2: return slv_aw_ready_o;
            3: return slv_w_ready_o;
            default: return slv_b_valid_o;
        endcase
    endfunction

    task automatic wait_for(input int which, input string what);
        int n;
        n = 0;
        @(negedge clk_i);
        while (probe(which) !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (n >= TIMEOUT) begin
            $display("Timeout while waiting for %s", what);
            test_errs++;
            aborted = 1'b1;
        end
    endtask

    task automatic run_read(input logic [AW-1:0] addr, input logic [IW-1:0] id,
                            input logic lock, output lrsc_pkg::axi_resp_u resp,
                            output logic [DW-1:0] data, output logic [IW-1:0] rid,
                            output logic last);
        slv_ar_addr_i  = addr;
        slv_ar_id_i    = id;
        slv_ar_lock_i  = lock;
        slv_ar_valid_i = 1'b1;
        wait_for(0, "AR ready");
        @(posedge clk_i);
        #1;
        slv_ar_valid_i = 1'b0;
        if (!aborted) wait_for(1, "R valid");
        resp.raw = slv_r_resp_o;
        data     = slv_r_data_o;
        rid      = slv_r_id_o;
        last     = slv_r_last_o;
        @(posedge clk_i);
        #1;
    endtask

    task automatic run_write(input logic [AW-1:0] addr, input logic [IW-1:0] id,
                             input logic lock, input logic [DW-1:0] data,
                             output lrsc_pkg::axi_resp_u resp, output logic [IW-1:0] bid);
        slv_aw_addr_i  = addr;
        slv_aw_id_i    = id;
        slv_aw_lock_i  = lock;
        slv_aw_valid_i = 1'b1;
        wait_for(2, "AW ready");
        @(posedge clk_i);
        #1;
        slv_aw_valid_i = 1'b0;
        slv_w_data_i   = data;
        slv_w_valid_i  = 1'b1;
        if (!aborted) wait_for(3, "W ready");
        @(posedge clk_i);
        #1;
        slv_w_valid_i = 1'b0;
        if (!aborted) wait_for(4, "B valid");
        resp.raw = slv_b_resp_o;
        bid      = slv_b_id_o;
        @(posedge clk_i);
        #1;
    endtask

    task automatic check_resp(input string name, input lrsc_pkg::axi_resp_u exp_v,
                              input lrsc_pkg::axi_resp_u act_v);
        if (act_v.raw !== exp_v.raw) begin
            $display("CHECK FAILED %s resp expected %0d actual %0d", name, exp_v.raw, act_v.raw);
            test_errs++;
        end
    endtask

    task automatic check_data(input string name, input logic [DW-1:0] exp_v,
                              input logic [DW-1:0] act_v);
        if (act_v !== exp_v) begin
            $display("CHECK FAILED %s data expected %h actual %h", name, exp_v, act_v);
            test_errs++;
        end
    endtask

    task automatic check_id(input string name, input logic [IW-1:0] exp_v,
                            input logic [IW-1:0] act_v);
        if (act_v !== exp_v) begin
            $display("CHECK FAILED %s id expected %0d actual %0d", name, exp_v, act_v);
            test_errs++;
        end
    endtask

    task automatic check_last(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("CHECK FAILED %s last expected %b actual %b", name, exp_v, act_v);
            test_errs++;
        end
    endtask

    initial begin
        int                  fd;
        int                  n_tests;
        int                  n_failed;
        int                  aw_before;
        string               line;
        string               name;
        string               op;
        logic [31:0]         addr, id, lock, data, err, exp_resp, exp_data;
        lrsc_pkg::axi_resp_u exp_u, act_u;
        logic [DW-1:0]       act_data;
        logic [IW-1:0]       act_id;
        logic                act_last;
        logic                drop;
        n_tests   = 0;
        n_failed  = 0;
        aborted   = 1'b0;
        slave_err = 1'b0;
        rst_ni    = 1'b1;
        {slv_ar_addr_i, slv_ar_id_i, slv_ar_len_i, slv_ar_lock_i, slv_ar_valid_i} = '0;
        {slv_aw_addr_i, slv_aw_id_i, slv_aw_len_i, slv_aw_lock_i, slv_aw_valid_i} = '0;
        {slv_w_data_i, slv_w_valid_i} = '0;
        {slv_w_strb_i, slv_w_last_i, slv_r_ready_i, slv_b_ready_i} = '1;
        #1;
        rst_ni = 1'b0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        fd = $fopen("lrsc_stim.txt", "r");
        if (fd == 0) $display("Cannot open the stimulus file lrsc_stim.txt");
        while (fd != 0 && !aborted && $fgets(line, fd) != 0) begin
            if ($sscanf(line, "%s %s %h %h %h %h %h %h %h", name, op, addr, id, lock, data,
                        err, exp_resp, exp_data) == 9) begin
                test_errs = 0;
                aw_before = aw_count;
                slave_err = err[0];
                exp_u.raw = exp_resp[1:0];
                // Locked window writes expected to answer OKAY must never go downstream
                drop = (op == "w") && lock[0] && (exp_u.raw == lrsc_pkg::RESP_OKAY) &&
                       (64'(addr) >= WIN_BEGIN) && (64'(addr) <= WIN_END);
                if (op == "r") begin
                    run_read(addr, id[IW-1:0], lock[0], act_u, act_data, act_id, act_last);
                end else begin
                    run_write(addr, id[IW-1:0], lock[0], data, act_u, act_id);
                    act_data = mem_read(addr);
                end
                if (!aborted) begin
                    check_resp(name, exp_u, act_u);
                    check_data(name, exp_data, act_data);
                    check_id(name, id[IW-1:0], act_id);
                    if (op == "r") check_last(name, 1'b1, act_last);
                end
                if (drop && aw_count != aw_before) begin
                    $display("Test %s: a failing exclusive write reached the memory side", name);
                    test_errs++;
                end
                n_tests++;
                if (test_errs != 0) n_failed++;
                $display("Test %s: %s", name, (test_errs == 0) ? "passed" : "failed");
            end
        end
        if (fd != 0) $fclose(fd);
        $display("Tests run %0d, passed %0d, failed %0d", n_tests, n_tests - n_failed, n_failed);
        if (n_failed == 0 && n_tests > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* lrsc_stim.txt */
# columns: name op(r/w) addr id lock wdata slave_error expected_resp expected_data
# for writes the expected data is the memory word after the write completes
wr_out       w 00000100 0 0 11111111 0 0 11111111
rd_out       r 00000100 0 0 00000000 0 0 11111111
wr_in        w 00001040 1 0 22222222 0 0 22222222
rd_in        r 00001040 1 0 00000000 0 0 22222222
exrd_out     r 00000100 2 1 00000000 0 0 11111111
exrd_in      r 00001040 2 1 00000000 0 1 22222222
exwr_ok      w 00001040 2 1 33333333 0 1 33333333
rd_new       r 00001040 0 0 00000000 0 0 33333333
exwr_nores   w 00001040 2 1 44444444 0 0 33333333
exrd_id3     r 00001040 3 1 00000000 0 1 33333333
exwr_badid   w 00001040 1 1 55555555 0 0 33333333
wr_clear     w 00001040 0 0 66666666 0 0 66666666
exwr_cleared w 00001040 3 1 77777777 0 0 66666666
rd_kept      r 00001040 0 0 00000000 0 0 66666666
rd_slverr    r 00000100 0 0 00000000 1 2 11111111
wr_slverr    w 00000100 1 0 88888888 1 2 11111111
wr_in2       w 00001080 2 0 99999999 0 0 99999999
exrd_slverr  r 00001080 2 1 00000000 1 2 99999999
exwr_slverr  w 00001080 2 1 aaaaaaaa 1 2 99999999
exwr_out     w 00000100 1 1 bbbbbbbb 0 0 bbbbbbbb
rd_out2      r 00000100 1 0 00000000 0 0 bbbbbbbb

/* sources.f */
lrsc_pkg.sv
lrsc_res_slot.sv
lrsc_read_ctrl.sv
lrsc_write_ctrl.sv
lrsc_adapter.sv
tb_lrsc.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator, the pass line in the output decides the status
verilator --binary --timing --timescale 1ns/100ps -f sources.f --top-module tb_lrsc \
    -o tb_lrsc &&
    ./obj_dir/tb_lrsc | tee /dev/stderr | grep -qx '>>> PASS' &&
    echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
